// ==== hw/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// First code fetch after reset
`define CORE_RESET_VECTOR 16'h0100

`define CORE_ADDR_W 16
`define CORE_DATA_W 16
`define CORE_BUS_W  8  // Code bus carries one byte

`endif

// ==== hw/isaPkg.sv ====
package isaPkg;

    // Sequencer phases
    typedef enum logic [2:0] {
        fetchOpcode, fetchModrm, fetchImmLo, fetchImmHi, execute, halted
    } phaseT;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        aluAdd, aluOr, aluAdc, aluSbb, aluAnd, aluSub, aluXor, aluCmp
    } aluOpT;

    // Jcc condition, opcode bits 3:1
    typedef enum logic [2:0] {
        condO, condC, condZ, condBe, condS, condP, condL, condLe
    } condT;

    // Byte width turns SP..DI into AH..BH
    typedef enum logic [2:0] {
        regAx, regCx, regDx, regBx, regSp, regBp, regSi, regDi
    } regIdxT;

    typedef enum logic [3:0] {
        aluRm, aluAcc, movRm, movImm, incDec, jcc, jmp, flagOp, outImm, outDx, hlt, nop
    } opClassT;

    // x86 FLAGS, low 12 bits
    typedef struct packed {
        logic ofFlag;
        logic dfFlag;
        logic ifFlag;
        logic tfFlag;
        logic sfFlag;
        logic zfFlag;
        logic fixed5;  // Always 0
        logic afFlag;
        logic fixed3;  // Always 0
        logic pfFlag;
        logic fixed1;  // Always 1
        logic cfFlag;
    } flagsT;

endpackage

// ==== hw/busPkg.sv ====
`include "core_cfg.svh"

package busPkg;

    // Wishbone classic, master side
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic [`CORE_ADDR_W-1:0] adr;
    } wbReqT;

    typedef struct packed {
        logic                   ack;
        logic [`CORE_BUS_W-1:0] dat;
    } wbRspT;

    // OUT instruction, no handshake
    typedef struct packed {
        logic                    strobe;
        logic                    wide;   // AX when set, else AL
        logic [`CORE_ADDR_W-1:0] addr;
        logic [`CORE_DATA_W-1:0] data;
    } portWriteT;

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module regFile (
    input  logic                    clk25,
    input  logic                    reset,
    input  isaPkg::regIdxT          rdSelA,
    input  isaPkg::regIdxT          rdSelB,
    input  logic                    rdWide,
    input  logic                    wrEn,
    input  isaPkg::regIdxT          wrSel,
    input  logic                    wrWide,
    input  logic [`CORE_DATA_W-1:0] wrData,
    output logic [`CORE_DATA_W-1:0] rdDataA,
    output logic [`CORE_DATA_W-1:0] rdDataB
);
    import isaPkg::*;

    logic [`CORE_DATA_W-1:0] regs [8];

    // Byte reads zero-extend, index 4..7 maps to the high half of 0..3
    function automatic logic [`CORE_DATA_W-1:0] readPort(input regIdxT sel, input logic wide);
        logic [`CORE_DATA_W-1:0] word;
        word = regs[{1'b0, sel[1:0]}];
        if (wide)
            readPort = regs[sel];
        else if (sel[2])
            readPort = {8'h00, word[15:8]};  // AH, CH, DH, BH
        else
            readPort = {8'h00, word[7:0]};
    endfunction

    always_comb begin
        rdDataA = readPort(rdSelA, rdWide);
        rdDataB = readPort(rdSelB, rdWide);
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            if (wrWide)
                regs[wrSel] <= wrData;
            else if (wrSel[2])
                regs[{1'b0, wrSel[1:0]}][15:8] <= wrData[7:0];
            else
                regs[wrSel][7:0] <= wrData[7:0];
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module alu (
    input  isaPkg::aluOpT           op,
    input  logic                    wide,
    input  logic [`CORE_DATA_W-1:0] a,
    input  logic [`CORE_DATA_W-1:0] b,
    input  isaPkg::flagsT           flagsIn,
    output logic [`CORE_DATA_W-1:0] result,
    output isaPkg::flagsT           flagsOut
);
    import isaPkg::*;

    logic [`CORE_DATA_W-1:0] opA;
    logic [`CORE_DATA_W-1:0] opB;
    logic [`CORE_DATA_W:0]   full;    // One extra bit for carry out
    logic [4:0]              nibble;  // Low nibble sum for AF
    logic [`CORE_DATA_W-1:0] raw;
    logic                    carryIn;
    logic                    isSub;
    logic                    isArith;
    logic                    signA;
    logic                    signB;
    logic                    signR;
    logic                    overflow;

    // Mask operands so byte carries land in bit 8
    assign opA = wide ? a : {8'h00, a[7:0]};
    assign opB = wide ? b : {8'h00, b[7:0]};

    assign isSub   = (op == aluSub) || (op == aluSbb) || (op == aluCmp);
    assign isArith = isSub || (op == aluAdd) || (op == aluAdc);
    assign carryIn = ((op == aluAdc) || (op == aluSbb)) ? flagsIn.cfFlag : 1'b0;

    always_comb begin
        nibble = '0;
        case (op)
            aluOr:  full = {1'b0, opA | opB};
            aluAnd: full = {1'b0, opA & opB};
            aluXor: full = {1'b0, opA ^ opB};
            default: begin
                if (isSub) begin
                    full   = {1'b0, opA} - {1'b0, opB} - carryIn;
                    nibble = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - carryIn;
                end else begin
                    full   = {1'b0, opA} + {1'b0, opB} + carryIn;
                    nibble = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + carryIn;
                end
            end
        endcase
    end

    assign raw    = full[`CORE_DATA_W-1:0];
    assign result = wide ? raw : {8'h00, raw[7:0]};

    // Sign bits at the operation width
    assign signA = wide ? opA[15] : opA[7];
    assign signB = wide ? opB[15] : opB[7];
    assign signR = wide ? raw[15] : raw[7];

    assign overflow = isSub ? (signA != signB) && (signR != signA)
                            : (signA == signB) && (signR != signA);

    always_comb begin
        flagsOut        = flagsIn;  // DF, IF, TF pass through
        flagsOut.fixed5 = 1'b0;
        flagsOut.fixed3 = 1'b0;
        flagsOut.fixed1 = 1'b1;
        flagsOut.ofFlag = isArith & overflow;
        flagsOut.sfFlag = signR;
        flagsOut.zfFlag = wide ? (raw == 16'h0000) : (raw[7:0] == 8'h00);
        flagsOut.afFlag = isArith & nibble[4];
        flagsOut.pfFlag = ~^raw[7:0];
        flagsOut.cfFlag = isArith & (wide ? full[16] : full[8]);
    end

endmodule

// ==== hw/byteFetch.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module byteFetch (
    input  logic                    clk25,
    input  logic                    reset,
    input  logic                    fetchReq,
    input  logic                    load,
    input  logic [`CORE_ADDR_W-1:0] loadValue,
    input  busPkg::wbRspT           wbRsp,
    output logic                    byteValid,
    output logic [`CORE_BUS_W-1:0]  byteData,
    output logic [`CORE_ADDR_W-1:0] ip,
    output busPkg::wbReqT           wbReq
);
    import busPkg::*;

    logic busy;  // Bus cycle in progress

    // Slave answers with data on the ack cycle
    assign byteValid = busy & wbRsp.ack;
    assign byteData  = wbRsp.dat;

    assign wbReq = wbReqT'{cyc: busy, stb: busy, adr: ip};

    always_ff @(posedge clk25) begin
        if (reset) begin
            ip   <= `CORE_RESET_VECTOR;
            busy <= 1'b0;
        end else if (load) begin
            ip   <= loadValue;  // Jump wins over a request
            busy <= 1'b0;
        end else if (busy) begin
            if (wbRsp.ack) begin
                ip   <= ip + 1'b1;
                busy <= 1'b0;   // cyc and stb drop after ack
            end
        end else if (fetchReq) begin
            busy <= 1'b1;
        end
    end

endmodule

// ==== hw/sequencer.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module sequencer (
    input  logic                    clk25,
    input  logic                    reset,
    input  logic                    byteValid,
    input  logic [`CORE_BUS_W-1:0]  byteData,
    input  logic [`CORE_ADDR_W-1:0] ip,
    input  logic [`CORE_DATA_W-1:0] rdDataA,
    input  logic [`CORE_DATA_W-1:0] rdDataB,
    input  logic [`CORE_DATA_W-1:0] aluResult,
    input  isaPkg::flagsT           aluFlags,
    output logic                    fetchReq,
    output logic                    load,
    output logic [`CORE_ADDR_W-1:0] loadValue,
    output isaPkg::regIdxT          rdSelA,
    output isaPkg::regIdxT          rdSelB,
    output logic                    rdWide,
    output logic                    wrEn,
    output isaPkg::regIdxT          wrSel,
    output logic                    wrWide,
    output logic [`CORE_DATA_W-1:0] wrData,
    output isaPkg::aluOpT           aluOp,
    output logic                    aluWide,
    output logic [`CORE_DATA_W-1:0] aluA,
    output logic [`CORE_DATA_W-1:0] aluB,
    output isaPkg::flagsT           flags,
    output busPkg::portWriteT       portWrite,
    output logic                    halted
);
    import isaPkg::*;
    import busPkg::*;

    phaseT                   phase;
    opClassT                 opClass;
    logic [7:0]              opcode;
    logic [7:0]              modrm;
    logic [`CORE_DATA_W-1:0] imm;
    logic                    opWide;
    logic                    needHi;
    logic                    isExec;
    regIdxT                  regDest;
    regIdxT                  regSrc;

    // ------------------------------
    // Decode helpers
    // ------------------------------
    function automatic opClassT decodeClass(input logic [7:0] op);
        casez (op)
            8'b00???0??: decodeClass = aluRm;
            8'b00???10?: decodeClass = aluAcc;
            8'b100010??: decodeClass = movRm;
            8'b1011????: decodeClass = movImm;
            8'b0100????: decodeClass = incDec;
            8'b0111????: decodeClass = jcc;
            8'hEB:       decodeClass = jmp;
            8'hF5, 8'hF8, 8'hF9: decodeClass = flagOp;
            8'hE6, 8'hE7: decodeClass = outImm;
            8'hEE, 8'hEF: decodeClass = outDx;
            8'hF4:       decodeClass = hlt;
            default:     decodeClass = nop;
        endcase
    endfunction

    function automatic phaseT firstPhase(input opClassT cls);
        case (cls)
            aluRm, movRm: firstPhase = fetchModrm;
            aluAcc, movImm, jcc, jmp, outImm: firstPhase = fetchImmLo;
            hlt:          firstPhase = isaPkg::halted;
            default:      firstPhase = execute;
        endcase
    endfunction

    function automatic logic condTrue(input condT c, input flagsT f);
        case (c)
            condO:   condTrue = f.ofFlag;
            condC:   condTrue = f.cfFlag;
            condZ:   condTrue = f.zfFlag;
            condBe:  condTrue = f.cfFlag | f.zfFlag;
            condS:   condTrue = f.sfFlag;
            condP:   condTrue = f.pfFlag;
            condL:   condTrue = f.sfFlag ^ f.ofFlag;
            default: condTrue = (f.sfFlag ^ f.ofFlag) | f.zfFlag;
        endcase
    endfunction

    always_comb begin
        case (opClass)
            movImm:  opWide = opcode[3];
            incDec:  opWide = 1'b1;
            default: opWide = opcode[0];
        endcase
    end

    assign needHi = (opClass == aluAcc && opcode[0]) || (opClass == movImm && opcode[3]);
    assign isExec = (phase == execute);

    // Direction bit picks which ModRM field is written
    assign regDest = opcode[1] ? regIdxT'(modrm[5:3]) : regIdxT'(modrm[2:0]);
    assign regSrc  = opcode[1] ? regIdxT'(modrm[2:0]) : regIdxT'(modrm[5:3]);

    assign fetchReq = (phase == fetchOpcode) || (phase == fetchModrm)
                   || (phase == fetchImmLo) || (phase == fetchImmHi);
    assign halted   = (phase == isaPkg::halted);

    // ------------------------------
    // Execute datapath steering
    // ------------------------------
    always_comb begin
        rdSelA    = regDest;
        rdSelB    = regSrc;
        rdWide    = opWide;
        wrEn      = 1'b0;
        wrSel     = regDest;
        wrWide    = opWide;
        wrData    = aluResult;
        aluOp     = aluOpT'(opcode[5:3]);
        aluWide   = opWide;
        aluA      = rdDataA;
        aluB      = rdDataB;
        load      = 1'b0;
        loadValue = ip + {{8{imm[7]}}, imm[7:0]};  // rel8 from the next byte
        portWrite = '0;
        case (opClass)
            aluRm: wrEn = isExec && (aluOpT'(opcode[5:3]) != aluCmp);
            aluAcc: begin
                rdSelA = regAx;
                wrSel  = regAx;
                aluB   = imm;
                wrEn   = isExec && (aluOpT'(opcode[5:3]) != aluCmp);
            end
            movRm: begin
                wrData = rdDataB;
                wrEn   = isExec;
            end
            movImm: begin
                wrSel  = regIdxT'(opcode[2:0]);
                wrData = imm;
                wrEn   = isExec;
            end
            incDec: begin
                rdSelA = regIdxT'(opcode[2:0]);
                wrSel  = regIdxT'(opcode[2:0]);
                aluOp  = opcode[3] ? aluSub : aluAdd;
                aluB   = 16'h0001;
                wrEn   = isExec;
            end
            jcc: load = isExec && (condTrue(condT'(opcode[3:1]), flags) ^ opcode[0]);
            jmp: load = isExec;
            outImm, outDx: begin
                rdSelA = regAx;
                rdSelB = regDx;
                rdWide = 1'b1;  // DX always full width
                portWrite.strobe = isExec;
                portWrite.wide   = opcode[0];
                portWrite.addr   = (opClass == outImm) ? {8'h00, imm[7:0]} : rdDataB;
                portWrite.data   = opcode[0] ? rdDataA : {8'h00, rdDataA[7:0]};
            end
            default: ;
        endcase
    end

    // ------------------------------
    // Phase and flags
    // ------------------------------
    always_ff @(posedge clk25) begin
        if (reset) begin
            phase   <= fetchOpcode;
            opClass <= nop;
            flags   <= 12'h002;
        end else begin
            case (phase)
                fetchOpcode: if (byteValid) begin
                    opClass <= decodeClass(byteData);
                    phase   <= firstPhase(decodeClass(byteData));
                end
                fetchModrm: if (byteValid) phase <= execute;
                fetchImmLo: if (byteValid) phase <= needHi ? fetchImmHi : execute;
                fetchImmHi: if (byteValid) phase <= execute;
                execute: begin
                    phase <= fetchOpcode;
                    case (opClass)
                        aluRm, aluAcc: flags <= aluFlags;  // CMP too
                        incDec: begin
                            flags        <= aluFlags;
                            flags.cfFlag <= flags.cfFlag;   // CF survives INC and DEC
                        end
                        flagOp: flags.cfFlag <= opcode[3] ? opcode[0] : ~flags.cfFlag;
                        default: ;
                    endcase
                end
                default: phase <= phase;  // Parked until reset
            endcase
        end
    end

    // Instruction bytes as they arrive
    always_ff @(posedge clk25) begin
        if (byteValid) begin
            case (phase)
                fetchOpcode: opcode <= byteData;
                fetchModrm:  modrm <= byteData;
                fetchImmLo:  imm <= {8'h00, byteData};
                fetchImmHi:  imm[15:8] <= byteData;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpuTop (
    input  logic              clk25,
    input  logic              reset,
    input  busPkg::wbRspT     wbRsp,
    output busPkg::wbReqT     wbReq,
    output busPkg::portWriteT portWrite,
    output logic              halted
);
    import isaPkg::*;

    logic                    fetchReq;
    logic                    load;
    logic [`CORE_ADDR_W-1:0] loadValue;
    logic                    byteValid;
    logic [`CORE_BUS_W-1:0]  byteData;
    logic [`CORE_ADDR_W-1:0] ip;
    regIdxT                  rdSelA;
    regIdxT                  rdSelB;
    logic                    rdWide;
    logic [`CORE_DATA_W-1:0] rdDataA;
    logic [`CORE_DATA_W-1:0] rdDataB;
    logic                    wrEn;
    regIdxT                  wrSel;
    logic                    wrWide;
    logic [`CORE_DATA_W-1:0] wrData;
    aluOpT                   aluOp;
    logic                    aluWide;
    logic [`CORE_DATA_W-1:0] aluA;
    logic [`CORE_DATA_W-1:0] aluB;
    logic [`CORE_DATA_W-1:0] aluResult;
    flagsT                   aluFlags;
    flagsT                   flags;

    regFile uRegFile (
        .clk25(clk25), .reset(reset),
        .rdSelA(rdSelA), .rdSelB(rdSelB), .rdWide(rdWide),
        .wrEn(wrEn), .wrSel(wrSel), .wrWide(wrWide), .wrData(wrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    alu uAlu (
        .op(aluOp), .wide(aluWide), .a(aluA), .b(aluB), .flagsIn(flags),
        .result(aluResult), .flagsOut(aluFlags)
    );

    byteFetch uByteFetch (
        .clk25(clk25), .reset(reset),
        .fetchReq(fetchReq), .load(load), .loadValue(loadValue), .wbRsp(wbRsp),
        .byteValid(byteValid), .byteData(byteData), .ip(ip), .wbReq(wbReq)
    );

    sequencer uSequencer (
        .clk25(clk25), .reset(reset),
        .byteValid(byteValid), .byteData(byteData), .ip(ip),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .aluResult(aluResult), .aluFlags(aluFlags),
        .fetchReq(fetchReq), .load(load), .loadValue(loadValue),
        .rdSelA(rdSelA), .rdSelB(rdSelB), .rdWide(rdWide),
        .wrEn(wrEn), .wrSel(wrSel), .wrWide(wrWide), .wrData(wrData),
        .aluOp(aluOp), .aluWide(aluWide), .aluA(aluA), .aluB(aluB),
        .flags(flags), .portWrite(portWrite), .halted(halted)
    );

endmodule

// ==== verification/portChecker.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module portChecker (
    input logic              clk25,
    input logic              reset,
    input busPkg::wbReqT     wbReq,
    input busPkg::wbRspT     wbRsp,
    input busPkg::portWriteT portWrite,
    input logic              halted
);
    import busPkg::*;

    typedef struct packed {
        logic        wide;
        logic [15:0] addr;
        logic [15:0] data;
    } expectT;

    expectT      expected[$];
    int          seen = 0;
    int          errors = 0;
    bit          active = 0;
    int          passCount = 0;
    int          failCount = 0;
    logic        firstCycle = 1'b0;  // First edge out of reset
    logic        firstFetch = 1'b1;
    logic        cycPending = 1'b0;  // Bus cycle still waiting for ack
    logic [15:0] cycAdr = '0;

    task automatic beginTest();
        expected.delete();
        seen   = 0;
        errors = 0;
        active = 1;
    endtask

    task automatic expectWrite(input logic [15:0] addr, input logic wide, input logic [15:0] data);
        expected.push_back(expectT'{wide: wide, addr: addr, data: data});
    endtask

    task automatic compareField(input string sig, input logic [15:0] exp, input logic [15:0] got);
        if (exp !== got) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic endTest(input string name, input bit timedOut);
        active = 0;
        if (timedOut) begin
            $display("%s: the core never reached HLT", name);
            errors++;
        end
        if (seen < expected.size()) begin
            $display("%s: %0d expected port writes never happened", name, expected.size() - seen);
            errors++;
        end
        if (errors == 0) begin
            passCount++;
            $display("PASS %s (%0d port writes)", name, seen);
        end else begin
            failCount++;
            $display("FAIL %s (%0d errors)", name, errors);
        end
    endtask

    // ------------------------------
    // Port writes in program order
    // ------------------------------
    always @(posedge clk25) begin
        if (active && !reset) begin
            if (portWrite.strobe) begin
                if (seen >= expected.size()) begin
                    $display("Unexpected extra port write to %h at %0t", portWrite.addr, $time);
                    errors++;
                end else begin
                    compareField("portWrite.addr", expected[seen].addr, portWrite.addr);
                    compareField("portWrite.wide", {15'd0, expected[seen].wide},
                                 {15'd0, portWrite.wide});
                    compareField("portWrite.data", expected[seen].data, portWrite.data);
                end
                seen++;
            end
            if (halted && (wbReq.cyc || wbReq.stb)) begin  // Bus must stay idle once halted
                $display("Bus cycle started after HLT at %0t", $time);
                errors++;
            end
        end
    end

    // ------------------------------
    // Wishbone master rules
    // ------------------------------
    always @(posedge clk25) begin
        if (reset) begin
            firstCycle <= 1'b1;
            firstFetch <= 1'b1;
            cycPending <= 1'b0;
        end else begin
            if (active) begin
                if (firstCycle) begin
                    compareField("wbReq.cyc", 16'd0, {15'd0, wbReq.cyc});
                    compareField("wbReq.stb", 16'd0, {15'd0, wbReq.stb});
                    compareField("portWrite.strobe", 16'd0, {15'd0, portWrite.strobe});
                    compareField("halted", 16'd0, {15'd0, halted});
                end
                if (wbReq.stb !== wbReq.cyc) begin
                    $display("Bus strobe and cycle lines disagree at %0t", $time);
                    errors++;
                end
                // Held until the slave acks
                if (cycPending) begin
                    compareField("wbReq.cyc", 16'd1, {15'd0, wbReq.cyc});
                    compareField("wbReq.adr", cycAdr, wbReq.adr);
                end
                if (firstFetch && wbReq.cyc)
                    compareField("wbReq.adr", `CORE_RESET_VECTOR, wbReq.adr);
            end
            firstCycle <= 1'b0;
            cycPending <= wbReq.cyc && !wbRsp.ack;
            cycAdr     <= wbReq.adr;
            if (wbReq.cyc)
                firstFetch <= 1'b0;
        end
    end

endmodule

// ==== verification/tbTop.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module tbTop;
    import busPkg::*;

    logic        clk25 = 1'b0;
    logic        reset = 1'b1;
    wbReqT       wbReq;
    wbRspT       wbRsp = '0;
    portWriteT   portWrite;
    logic        halted;
    logic [7:0]  mem [65536];
    logic [31:0] rngState = 32'd16545;
    logic        pending = 1'b0;
    logic [1:0]  waitLeft = 2'd0;
    int          testCount = 0;

    cpuTop dut (
        .clk25(clk25), .reset(reset), .wbRsp(wbRsp),
        .wbReq(wbReq), .portWrite(portWrite), .halted(halted)
    );

    portChecker chk (
        .clk25(clk25), .reset(reset), .wbReq(wbReq), .wbRsp(wbRsp),
        .portWrite(portWrite), .halted(halted)
    );

    initial begin
        forever #50 clk25 = ~clk25;  // 100 ns period
    end

    function automatic logic [31:0] nextRand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        nextRand = x;
    endfunction

    function automatic int hexDigit(input byte c);
        if (c >= "0" && c <= "9")
            hexDigit = c - "0";
        else if (c >= "a" && c <= "f")
            hexDigit = c - "a" + 10;
        else if (c >= "A" && c <= "F")
            hexDigit = c - "A" + 10;
        else
            hexDigit = -1;
    endfunction

    // ------------------------------
    // Code memory with 0 to 3 wait states
    // ------------------------------
    always @(posedge clk25) begin
        #1;
        if (reset) begin
            wbRsp   = '0;
            pending = 1'b0;
        end else if (wbRsp.ack) begin
            wbRsp.ack = 1'b0;  // Master dropped cyc on this edge
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!pending) begin
                pending  = 1'b1;
                rngState = nextRand(rngState);
                waitLeft = rngState[1:0];
            end
            if (waitLeft == 2'd0) begin
                wbRsp.ack = 1'b1;
                wbRsp.dat = mem[wbReq.adr];
                pending   = 1'b0;
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
    end

    task automatic fillMemory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
        end
    endtask

    // Hex bytes after the keyword go from addr upward
    task automatic loadBytes(input string line, inout int addr);
        int         nib;
        int         digits;
        logic [7:0] value;
        byte        c;
        digits = 0;
        value  = 8'h00;
        for (int i = 4; i <= line.len(); i++) begin
            c   = (i < line.len()) ? line[i] : " ";
            nib = hexDigit(c);
            if (nib >= 0) begin
                value = {value[3:0], nib[3:0]};
                digits++;
            end else if (digits > 0) begin
                mem[addr[15:0]] = value;
                addr++;
                digits = 0;
                value  = 8'h00;
            end
        end
    endtask

    task automatic applyReset();
        @(posedge clk25);
        #1 reset = 1'b1;
        repeat (5) @(posedge clk25);
        #1 reset = 1'b0;
    endtask

    task automatic runTest(input string name);
        int cycles;
        applyReset();
        cycles = 0;
        while (!halted && cycles < 4000) begin
            @(posedge clk25);
            #1;
            cycles++;
        end
        repeat (4) @(posedge clk25);  // Watch the bus stay quiet
        #2;
        chk.endTest(name, !halted);
        testCount++;
    endtask

    // ------------------------------
    // Data file driven test loop
    // ------------------------------
    initial begin
        int          fd;
        int          n;
        int          addr;
        int          outWide;
        bit          openFailed;
        logic [15:0] outAddr;
        logic [15:0] outData;
        string       line;
        string       key;
        string       name;
        openFailed = 0;
        addr       = `CORE_RESET_VECTOR;
        name       = "unnamed";
        fd = $fopen("verification/core_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/core_tests.txt");
            openFailed = 1;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                key = "";
                if (n > 0)
                    void'($sscanf(line, "%s", key));
                case (key)
                    "test": begin
                        void'($sscanf(line, "test %s", name));
                        chk.beginTest();
                        fillMemory();
                        addr = `CORE_RESET_VECTOR;
                    end
                    "prog": loadBytes(line, addr);
                    "out": begin
                        void'($sscanf(line, "out %h %d %h", outAddr, outWide, outData));
                        chk.expectWrite(outAddr, outWide[0], outData);
                    end
                    "end": runTest(name);
                    default: ;  // Comments and blank lines
                endcase
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d passed, %0d failed",
                 testCount, chk.passCount, chk.failCount);
        if (!openFailed && testCount > 0 && chk.failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/isaPkg.sv
hw/busPkg.sv
hw/regFile.sv
hw/alu.sv
hw/byteFetch.sv
hw/sequencer.sv
hw/cpuTop.sv
verification/portChecker.sv
verification/tbTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tbTop -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation executable exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

// ==== verification/core_tests.txt ====
# test NAME / prog HEX BYTES from the reset vector / out PORT WIDE(1=AX) DATA / end
# Lines starting with # are ignored
test mov_out
prog B0 12 B4 34 B7 56 BA 80 00 E7 10 EE 8A C7 E6 20 F4
out 0010 1 3412
out 0080 0 0012
out 0020 0 0056
end
test alu_reg_reg
prog B8 34 12 BB 0F 0F 01 D8 E7 01 09 D8 E7 02 21 D8 E7 03 31 D8 E7 04
prog 29 D8 E7 05 39 D8 E7 06 11 D8 E7 07 19 D8 E7 08 F4
out 0001 1 2143
out 0002 1 2F4F
out 0003 1 0F0F
out 0004 1 0000
out 0005 1 F0F1
out 0006 1 F0F1
out 0007 1 0000
out 0008 1 F0F0
end
test alu_acc_imm
prog B8 FF 00 04 01 E7 01 14 05 E6 02 0C F0 E6 03 24 3C E6 04 34 FF E6 05
prog 2C D0 E6 06 1C 0A E6 07 3C F0 74 02 E6 AA E6 08 05 01 00 2D F2 00 E7 09 F4
out 0001 1 0000
out 0002 0 0006
out 0003 0 00F6
out 0004 0 0034
out 0005 0 00CB
out 0006 0 00FB
out 0007 0 00F0
out 0008 0 00F0
out 0009 1 FFFF
end
test jcc_all
prog 31 C0 74 02 E6 01 75 02 E6 02 7A 02 E6 03 7B 02 E6 04 78 02 E6 05
prog 76 02 E6 06 7E 02 E6 07 7C 02 E6 08 70 02 E6 09 72 02 E6 0A
prog F9 72 02 E6 0B 73 02 E6 0C B0 7F 04 01 70 02 E6 0D 71 02 E6 0E
prog 79 02 E6 0F 7D 02 E6 10 7F 02 E6 11 7A 02 E6 12 77 02 E6 13
prog F5 77 02 E6 14 F8 73 02 E6 15 2C 01 7C 02 E6 16 7F 02 E6 17
prog EB 02 E6 18 E6 19 F4
out 0002 0 0000
out 0004 0 0000
out 0005 0 0000
out 0008 0 0000
out 0009 0 0000
out 000A 0 0000
out 000C 0 0000
out 000E 0 0080
out 000F 0 0080
out 0012 0 0080
out 0014 0 0080
out 0017 0 007F
out 0019 0 007F
end
test inc_dec
prog B9 FF FF F9 41 72 02 E6 01 89 C8 E7 02 F8 48 73 02 E6 03 E7 04
prog BA 00 80 4A 70 02 E6 05 89 D0 EF F4
out 0002 1 0000
out 0004 1 FFFF
out 7FFF 1 7FFF
end
